/* csr_macros.svh */
// CSR unit constants
// Data width, machine-mode CSR addresses, the mtvec write mask and the
// SYSTEM opcode shared by the decoder, the CSR file and the checker
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Width of a data word and of every CSR
`define CSR_XLEN 32

// Machine scratch register
`define CSR_ADDR_MSCRATCH 12'h340

// Machine trap vector base
`define CSR_ADDR_MTVEC 12'h305

// Machine cycle counter
`define CSR_ADDR_MCYCLE 12'hB00

// Only direct mode is supported
// The two mode bits of mtvec are hard-wired to zero
`define CSR_MTVEC_WMASK {{(`CSR_XLEN-2){1'b1}}, 2'b00}

// Major opcode shared by all CSR instructions
`define CSR_OPCODE_SYSTEM 7'b1110011

`endif

/* csr_pkg.sv */
// CSR unit types
// Operation encoding and the word and address types used on every
// stage boundary of the CSR execution unit
`include "csr_macros.svh"

package csr_pkg;

	// The encoding follows funct3 bits 13:12 of the instruction directly
	// so the decoder only has to cast the field
	// Bit 14 only selects the immediate operand and is not part of it
	typedef enum logic [1:0] {
		CSR_OP_NONE  = 2'd0,
		CSR_OP_WRITE = 2'd1,
		CSR_OP_SET   = 2'd2,
		CSR_OP_CLEAR = 2'd3
	} csr_op_t;

	// One register-sized data word
	// Used for operands, pc values, CSR contents and masks
	typedef logic [`CSR_XLEN-1:0] word_t;

	// The CSR address field taken from instruction bits 31:20
	typedef logic [11:0] csr_addr_t;

endpackage

/* csr_insn_decode.sv */
// CSR instruction decoder
// Recognises CSR accesses among strobed instructions and registers the
// operation, address, destination, operand and pc for the CSR file
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_insn_decode (
	input  logic                clock,
	input  logic                reset,
	input  logic                insn_valid,
	input  logic [31:0]         insn,
	input  csr_pkg::word_t      pc,
	input  csr_pkg::word_t      rs1_rdata,
	output logic                dec_valid,
	output csr_pkg::csr_op_t    dec_op,
	output csr_pkg::csr_addr_t  dec_addr,
	output logic [4:0]          dec_rd,
	output csr_pkg::word_t      dec_arg,
	output csr_pkg::word_t      dec_pc
);

	logic [6:0]     opcode;
	logic [2:0]     funct3;
	logic [4:0]     uimm;
	logic           is_csr;
	csr_pkg::word_t arg;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];

	// The rs1 field doubles as a 5-bit unsigned immediate in the I forms
	assign uimm = insn[19:15];

	// A funct3 low pair of zero is ECALL, EBREAK or a return, not a CSR access
	assign is_csr = (opcode == `CSR_OPCODE_SYSTEM) && (funct3[1:0] != 2'b00);

	// Bit 14 of the instruction picks the zero-extended immediate over rs1
	assign arg = funct3[2] ? {{(`CSR_XLEN-5){1'b0}}, uimm} : rs1_rdata;

	// Only the strobe is control state
	// Anything else on the bus is simply not passed on
	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= insn_valid && is_csr;
		end
	end

	// Fields are captured on every strobe
	// They are only looked at while dec_valid is high
	always_ff @(posedge clock) begin
		if (insn_valid) begin
			dec_op   <= csr_pkg::csr_op_t'(funct3[1:0]);
			dec_addr <= insn[31:20];
			dec_rd   <= insn[11:7];
			dec_arg  <= arg;
			dec_pc   <= pc;
		end
	end

	// The decoder never invents an instruction on a quiet cycle
	a_no_spurious_valid: assert property (@(posedge clock) disable iff (reset)
		!insn_valid |=> !dec_valid);

endmodule

/* csr_file.sv */
// Machine-mode CSR file
// Holds mscratch, mtvec and mcycle, executes read-write, set and clear
// operations and produces the retirement fields, including traps
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_file (
	input  logic                clock,
	input  logic                reset,
	input  logic                dec_valid,
	input  csr_pkg::csr_op_t    dec_op,
	input  csr_pkg::csr_addr_t  dec_addr,
	input  logic [4:0]          dec_rd,
	input  csr_pkg::word_t      dec_arg,
	input  csr_pkg::word_t      dec_pc,
	output logic                ex_valid,
	output logic                ex_trap,
	output logic [4:0]          ex_rd_addr,
	output csr_pkg::word_t      ex_rd_wdata,
	output csr_pkg::word_t      ex_pc_rdata,
	output csr_pkg::word_t      ex_pc_wdata,
	output csr_pkg::word_t      ex_csr_rmask,
	output csr_pkg::word_t      ex_csr_wmask,
	output csr_pkg::word_t      ex_csr_rdata,
	output csr_pkg::word_t      ex_csr_wdata
);

	csr_pkg::word_t mscratch;
	csr_pkg::word_t mtvec;
	csr_pkg::word_t mcycle;

	logic           hit_mscratch;
	logic           hit_mtvec;
	logic           hit_mcycle;
	logic           misaligned;
	logic           trap;
	logic           do_write;
	csr_pkg::word_t old_value;
	csr_pkg::word_t writable;
	csr_pkg::word_t wmask;
	csr_pkg::word_t new_value;
	csr_pkg::word_t merged;
	csr_pkg::word_t rmask;

	assign hit_mscratch = dec_addr == `CSR_ADDR_MSCRATCH;
	assign hit_mtvec    = dec_addr == `CSR_ADDR_MTVEC;
	assign hit_mcycle   = dec_addr == `CSR_ADDR_MCYCLE;

	// Instructions are 4 bytes and there is no compressed support
	assign misaligned = dec_pc[1:0] != 2'b00;

	// An unknown address counts as an illegal instruction
	assign trap = !(hit_mscratch || hit_mtvec || hit_mcycle) || misaligned;

	// Current contents and the writable bits of the addressed register
	always_comb begin
		old_value = '0;
		writable  = '0;
		if (hit_mscratch) begin
			old_value = mscratch;
			writable  = '1;
		end else if (hit_mtvec) begin
			old_value = mtvec;
			writable  = `CSR_MTVEC_WMASK;
		end else if (hit_mcycle) begin
			old_value = mcycle;
			writable  = '1;
		end
	end

	// A write claims every writable bit, set and clear only the operand bits
	always_comb begin
		case (dec_op)
			csr_pkg::CSR_OP_WRITE: begin
				wmask     = writable;
				new_value = dec_arg;
			end
			csr_pkg::CSR_OP_SET: begin
				wmask     = dec_arg & writable;
				new_value = old_value | dec_arg;
			end
			csr_pkg::CSR_OP_CLEAR: begin
				wmask     = dec_arg & writable;
				new_value = old_value & ~dec_arg;
			end
			default: begin
				wmask     = '0;
				new_value = old_value;
			end
		endcase
		// A trapping instruction touches nothing
		if (trap) begin
			wmask = '0;
		end
	end

	// Bits outside the mask keep their old value, so mtvec mode bits stay zero
	assign merged = (new_value & wmask) | (old_value & ~wmask);

	// The CSR is only architecturally read when the result is kept
	assign rmask = (!trap && dec_rd != 5'd0) ? '1 : '0;

	// A set or clear with a zero operand is not a write at all
	assign do_write = dec_valid && (wmask != '0);

	// Register update happens on the edge that launches the record, so the
	// next instruction in the pipeline already sees the new contents
	always_ff @(posedge clock) begin
		if (reset) begin
			mscratch <= '0;
			mtvec    <= '0;
			mcycle   <= '0;
		end else begin
			if (do_write && hit_mscratch) begin
				mscratch <= merged;
			end
			if (do_write && hit_mtvec) begin
				mtvec <= merged;
			end
			// An explicit write replaces the count for this cycle
			if (do_write && hit_mcycle) begin
				mcycle <= merged;
			end else begin
				mcycle <= mcycle + csr_pkg::word_t'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
		end
	end

	// Result fields of the executed instruction
	// mtvec is the trap target in direct mode
	always_ff @(posedge clock) begin
		ex_trap      <= trap;
		ex_rd_addr   <= trap ? 5'd0 : dec_rd;
		ex_rd_wdata  <= rmask & old_value;
		ex_pc_rdata  <= dec_pc;
		ex_pc_wdata  <= trap ? mtvec : dec_pc + csr_pkg::word_t'(4);
		ex_csr_rmask <= rmask;
		ex_csr_wmask <= wmask;
		ex_csr_rdata <= trap ? '0 : old_value;
		ex_csr_wdata <= trap ? '0 : merged;
	end

	// A trap retires with neither a CSR read nor a CSR write
	a_trap_no_masks: assert property (@(posedge clock) disable iff (reset)
		(ex_valid && ex_trap) |-> (ex_csr_rmask == '0 && ex_csr_wmask == '0));

	// The mtvec mode bits are never reported as written
	a_mtvec_mode_ro: assert property (@(posedge clock) disable iff (reset)
		(dec_valid && hit_mtvec) |=> (ex_csr_wmask[1:0] == 2'b00));

endmodule

/* csr_retire.sv */
// Retirement stage
// Registers the executed instruction into an RVFI-style record and
// drives all fields to zero on cycles without a retiring instruction
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_retire (
	input  logic            clock,
	input  logic            reset,
	input  logic            ex_valid,
	input  logic            ex_trap,
	input  logic [4:0]      ex_rd_addr,
	input  csr_pkg::word_t  ex_rd_wdata,
	input  csr_pkg::word_t  ex_pc_rdata,
	input  csr_pkg::word_t  ex_pc_wdata,
	input  csr_pkg::word_t  ex_csr_rmask,
	input  csr_pkg::word_t  ex_csr_wmask,
	input  csr_pkg::word_t  ex_csr_rdata,
	input  csr_pkg::word_t  ex_csr_wdata,
	output logic            rvfi_valid,
	output logic            rvfi_trap,
	output logic [4:0]      rvfi_rd_addr,
	output csr_pkg::word_t  rvfi_rd_wdata,
	output csr_pkg::word_t  rvfi_pc_rdata,
	output csr_pkg::word_t  rvfi_pc_wdata,
	output csr_pkg::word_t  rvfi_csr_rmask,
	output csr_pkg::word_t  rvfi_csr_wmask,
	output csr_pkg::word_t  rvfi_csr_rdata,
	output csr_pkg::word_t  rvfi_csr_wdata
);

	// Idle records read as all zero so a monitor never sees stale data
	always_ff @(posedge clock) begin
		if (reset || !ex_valid) begin
			rvfi_valid     <= 1'b0;
			rvfi_trap      <= 1'b0;
			rvfi_rd_addr   <= 5'd0;
			rvfi_rd_wdata  <= '0;
			rvfi_pc_rdata  <= '0;
			rvfi_pc_wdata  <= '0;
			rvfi_csr_rmask <= '0;
			rvfi_csr_wmask <= '0;
			rvfi_csr_rdata <= '0;
			rvfi_csr_wdata <= '0;
		end else begin
			rvfi_valid     <= 1'b1;
			rvfi_trap      <= ex_trap;
			rvfi_rd_addr   <= ex_rd_addr;
			rvfi_rd_wdata  <= ex_rd_wdata;
			rvfi_pc_rdata  <= ex_pc_rdata;
			rvfi_pc_wdata  <= ex_pc_wdata;
			rvfi_csr_rmask <= ex_csr_rmask;
			rvfi_csr_wmask <= ex_csr_wmask;
			rvfi_csr_rdata <= ex_csr_rdata;
			rvfi_csr_wdata <= ex_csr_wdata;
		end
	end

	// x0 is never written with anything but zero
	a_x0_zero: assert property (@(posedge clock) disable iff (reset)
		(rvfi_rd_addr == 5'd0) |-> (rvfi_rd_wdata == '0));

endmodule

/* csr_write_check.sv */
// CSR write checker
// Compares each retirement record against the architectural CSR access
// rules and keeps a sticky error flag once any record breaks them
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_write_check (
	input  logic            clock,
	input  logic            reset,
	input  logic            rvfi_valid,
	input  logic            rvfi_trap,
	input  logic [4:0]      rvfi_rd_addr,
	input  csr_pkg::word_t  rvfi_rd_wdata,
	input  csr_pkg::word_t  rvfi_pc_rdata,
	input  csr_pkg::word_t  rvfi_pc_wdata,
	input  csr_pkg::word_t  rvfi_csr_rmask,
	input  csr_pkg::word_t  rvfi_csr_wmask,
	input  csr_pkg::word_t  rvfi_csr_rdata,
	input  csr_pkg::word_t  rvfi_csr_wdata,
	output logic            check_error
);

	csr_pkg::word_t spec_pc_wdata;
	csr_pkg::word_t changed;
	logic           trap_ok;
	logic           pc_ok;
	logic           rd_ok;
	logic           wmask_ok;
	logic           violation;

	// Every CSR instruction is a plain 4-byte step when it does not trap
	assign spec_pc_wdata = rvfi_pc_rdata + csr_pkg::word_t'(4);

	// Bits that differ between the old and the new CSR value
	assign changed = rvfi_csr_wdata ^ rvfi_csr_rdata;

	// A trap must neither write rd nor read or write the CSR
	assign trap_ok = !rvfi_trap ||
		(rvfi_rd_addr == 5'd0 && rvfi_rd_wdata == '0 &&
		rvfi_csr_rmask == '0 && rvfi_csr_wmask == '0);

	assign pc_ok = rvfi_trap || (rvfi_pc_wdata == spec_pc_wdata);

	// With a live rd the whole CSR is read and returned unchanged
	assign rd_ok = (rvfi_rd_addr == 5'd0) ? (rvfi_rd_wdata == '0) :
		(rvfi_csr_rmask == '1 && rvfi_rd_wdata == rvfi_csr_rdata);

	// The operand is not part of the record, so set and clear masks cannot
	// be rebuilt here
	// What can be checked is that only bits under the write mask change
	assign wmask_ok = (changed & ~rvfi_csr_wmask) == '0;

	assign violation = rvfi_valid && !(trap_ok && pc_ok && rd_ok && wmask_ok);

	// Sticky until the next reset
	always_ff @(posedge clock) begin
		if (reset) begin
			check_error <= 1'b0;
		end else if (violation) begin
			check_error <= 1'b1;
		end
	end

	a_trap_rd: assert property (@(posedge clock) disable iff (reset)
		(rvfi_valid && rvfi_trap) |-> (rvfi_rd_addr == 5'd0 && rvfi_rd_wdata == '0));

	a_next_pc: assert property (@(posedge clock) disable iff (reset)
		(rvfi_valid && !rvfi_trap) |-> (rvfi_pc_wdata == spec_pc_wdata));

	a_rd_data: assert property (@(posedge clock) disable iff (reset)
		(rvfi_valid && rvfi_rd_addr != 5'd0) |-> (rvfi_rd_wdata == rvfi_csr_rdata));

	a_wdata_in_mask: assert property (@(posedge clock) disable iff (reset)
		rvfi_valid |-> ((changed & ~rvfi_csr_wmask) == '0));

endmodule

/* csr_unit_top.sv */
// CSR execution unit top level
// Chains decode, CSR file and retirement, with the write checker
// watching the retirement record
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_unit_top (
	input  logic            clock,
	input  logic            reset,
	input  logic            insn_valid,
	input  logic [31:0]     insn,
	input  csr_pkg::word_t  pc,
	input  csr_pkg::word_t  rs1_rdata,
	output logic            rvfi_valid,
	output logic            rvfi_trap,
	output logic [4:0]      rvfi_rd_addr,
	output csr_pkg::word_t  rvfi_rd_wdata,
	output csr_pkg::word_t  rvfi_pc_rdata,
	output csr_pkg::word_t  rvfi_pc_wdata,
	output csr_pkg::word_t  rvfi_csr_rmask,
	output csr_pkg::word_t  rvfi_csr_wmask,
	output csr_pkg::word_t  rvfi_csr_rdata,
	output csr_pkg::word_t  rvfi_csr_wdata,
	output logic            check_error
);

	// Decoded instruction
	logic               dec_valid;
	csr_pkg::csr_op_t   dec_op;
	csr_pkg::csr_addr_t dec_addr;
	logic [4:0]         dec_rd;
	csr_pkg::word_t     dec_arg;
	csr_pkg::word_t     dec_pc;

	// Executed instruction
	logic               ex_valid;
	logic               ex_trap;
	logic [4:0]         ex_rd_addr;
	csr_pkg::word_t     ex_rd_wdata;
	csr_pkg::word_t     ex_pc_rdata;
	csr_pkg::word_t     ex_pc_wdata;
	csr_pkg::word_t     ex_csr_rmask;
	csr_pkg::word_t     ex_csr_wmask;
	csr_pkg::word_t     ex_csr_rdata;
	csr_pkg::word_t     ex_csr_wdata;

	csr_insn_decode i_csr_insn_decode (
		.clock      (clock),
		.reset      (reset),
		.insn_valid (insn_valid),
		.insn       (insn),
		.pc         (pc),
		.rs1_rdata  (rs1_rdata),
		.dec_valid  (dec_valid),
		.dec_op     (dec_op),
		.dec_addr   (dec_addr),
		.dec_rd     (dec_rd),
		.dec_arg    (dec_arg),
		.dec_pc     (dec_pc)
	);

	csr_file i_csr_file (
		.clock        (clock),
		.reset        (reset),
		.dec_valid    (dec_valid),
		.dec_op       (dec_op),
		.dec_addr     (dec_addr),
		.dec_rd       (dec_rd),
		.dec_arg      (dec_arg),
		.dec_pc       (dec_pc),
		.ex_valid     (ex_valid),
		.ex_trap      (ex_trap),
		.ex_rd_addr   (ex_rd_addr),
		.ex_rd_wdata  (ex_rd_wdata),
		.ex_pc_rdata  (ex_pc_rdata),
		.ex_pc_wdata  (ex_pc_wdata),
		.ex_csr_rmask (ex_csr_rmask),
		.ex_csr_wmask (ex_csr_wmask),
		.ex_csr_rdata (ex_csr_rdata),
		.ex_csr_wdata (ex_csr_wdata)
	);

	csr_retire i_csr_retire (
		.clock          (clock),
		.reset          (reset),
		.ex_valid       (ex_valid),
		.ex_trap        (ex_trap),
		.ex_rd_addr     (ex_rd_addr),
		.ex_rd_wdata    (ex_rd_wdata),
		.ex_pc_rdata    (ex_pc_rdata),
		.ex_pc_wdata    (ex_pc_wdata),
		.ex_csr_rmask   (ex_csr_rmask),
		.ex_csr_wmask   (ex_csr_wmask),
		.ex_csr_rdata   (ex_csr_rdata),
		.ex_csr_wdata   (ex_csr_wdata),
		.rvfi_valid     (rvfi_valid),
		.rvfi_trap      (rvfi_trap),
		.rvfi_rd_addr   (rvfi_rd_addr),
		.rvfi_rd_wdata  (rvfi_rd_wdata),
		.rvfi_pc_rdata  (rvfi_pc_rdata),
		.rvfi_pc_wdata  (rvfi_pc_wdata),
		.rvfi_csr_rmask (rvfi_csr_rmask),
		.rvfi_csr_wmask (rvfi_csr_wmask),
		.rvfi_csr_rdata (rvfi_csr_rdata),
		.rvfi_csr_wdata (rvfi_csr_wdata)
	);

	csr_write_check i_csr_write_check (
		.clock          (clock),
		.reset          (reset),
		.rvfi_valid     (rvfi_valid),
		.rvfi_trap      (rvfi_trap),
		.rvfi_rd_addr   (rvfi_rd_addr),
		.rvfi_rd_wdata  (rvfi_rd_wdata),
		.rvfi_pc_rdata  (rvfi_pc_rdata),
		.rvfi_pc_wdata  (rvfi_pc_wdata),
		.rvfi_csr_rmask (rvfi_csr_rmask),
		.rvfi_csr_wmask (rvfi_csr_wmask),
		.rvfi_csr_rdata (rvfi_csr_rdata),
		.rvfi_csr_wdata (rvfi_csr_wdata),
		.check_error    (check_error)
	);

endmodule

/* tb_csr_unit.sv */
// Testbench for the CSR execution unit
// Streams a table of CSR instructions back to back, predicts every
// retirement record with a register model and checks it on arrival
`timescale 1ns/1ns
`include "csr_macros.svh"

module tb_csr_unit;

	localparam int N_TESTS        = 21;
	localparam int LATENCY        = 3;
	localparam int CYCLE_SPAN     = N_TESTS * 4;
	localparam int TIMEOUT_CYCLES = N_TESTS * 4 + 50;

	// How the record of an entry is checked
	localparam int PLAIN       = 0;
	localparam int CYCLE_WRITE = 1;
	localparam int CYCLE_READ  = 2;

	localparam csr_pkg::csr_op_t OP_RW = csr_pkg::CSR_OP_WRITE;
	localparam csr_pkg::csr_op_t OP_RS = csr_pkg::CSR_OP_SET;
	localparam csr_pkg::csr_op_t OP_RC = csr_pkg::CSR_OP_CLEAR;
	localparam logic REG = 1'b0;
	localparam logic IMM = 1'b1;
	localparam logic [11:0] ADDR_SCRATCH = `CSR_ADDR_MSCRATCH;
	localparam logic [11:0] ADDR_TVEC    = `CSR_ADDR_MTVEC;
	localparam logic [11:0] ADDR_CYCLE   = `CSR_ADDR_MCYCLE;
	// mepc exists in real cores but not in this unit
	localparam logic [11:0] ADDR_BAD     = 12'h341;
	localparam logic [31:0] PC_BASE      = 32'h8000_0000;

	logic           clock = 1'b0;
	logic           reset;
	logic           insn_valid;
	logic [31:0]    insn;
	csr_pkg::word_t pc;
	csr_pkg::word_t rs1_rdata;
	logic           rvfi_valid;
	logic           rvfi_trap;
	logic [4:0]     rvfi_rd_addr;
	csr_pkg::word_t rvfi_rd_wdata;
	csr_pkg::word_t rvfi_pc_rdata;
	csr_pkg::word_t rvfi_pc_wdata;
	csr_pkg::word_t rvfi_csr_rmask;
	csr_pkg::word_t rvfi_csr_wmask;
	csr_pkg::word_t rvfi_csr_rdata;
	csr_pkg::word_t rvfi_csr_wdata;
	logic           check_error;

	// Stimulus table, one slot per instruction
	string            t_name [N_TESTS];
	csr_pkg::csr_op_t t_op   [N_TESTS];
	logic             t_imm  [N_TESTS];
	logic [11:0]      t_addr [N_TESTS];
	logic [4:0]       t_rd   [N_TESTS];
	csr_pkg::word_t   t_arg  [N_TESTS];
	csr_pkg::word_t   t_pc   [N_TESTS];
	logic             t_trap [N_TESTS];
	int               t_kind [N_TESTS];
	int               n_entries;

	// Predicted record fields
	logic [4:0]     e_rd_addr  [N_TESTS];
	csr_pkg::word_t e_rd_wdata [N_TESTS];
	csr_pkg::word_t e_pc_wdata [N_TESTS];
	csr_pkg::word_t e_rmask    [N_TESTS];
	csr_pkg::word_t e_wmask    [N_TESTS];
	csr_pkg::word_t e_rdata    [N_TESTS];
	csr_pkg::word_t e_wdata    [N_TESTS];
	int             issue_edge [N_TESTS];

	// Architectural model state
	csr_pkg::word_t m_mscratch;
	csr_pkg::word_t m_mtvec;
	csr_pkg::word_t m_mcycle_base;

	logic [31:0] lcg_state;
	int          edge_count = 0;
	int          retired = 0;
	int          pending_q [$];

	csr_unit_top i_csr_unit_top (
		.clock          (clock),
		.reset          (reset),
		.insn_valid     (insn_valid),
		.insn           (insn),
		.pc             (pc),
		.rs1_rdata      (rs1_rdata),
		.rvfi_valid     (rvfi_valid),
		.rvfi_trap      (rvfi_trap),
		.rvfi_rd_addr   (rvfi_rd_addr),
		.rvfi_rd_wdata  (rvfi_rd_wdata),
		.rvfi_pc_rdata  (rvfi_pc_rdata),
		.rvfi_pc_wdata  (rvfi_pc_wdata),
		.rvfi_csr_rmask (rvfi_csr_rmask),
		.rvfi_csr_wmask (rvfi_csr_wmask),
		.rvfi_csr_rdata (rvfi_csr_rdata),
		.rvfi_csr_wdata (rvfi_csr_wdata),
		.check_error    (check_error)
	);

	always #10 clock = ~clock;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Register forms read rs1 = x1, immediate forms carry the operand in the rs1 field
	function automatic logic [31:0] encode_csr(input int i);
		logic [4:0] src;
		src = t_imm[i] ? t_arg[i][4:0] : 5'd1;
		return {t_addr[i], src, t_imm[i], t_op[i], t_rd[i], `CSR_OPCODE_SYSTEM};
	endfunction

	task automatic add_entry(input string name, input csr_pkg::csr_op_t op, input logic imm,
		input logic [11:0] addr, input logic [4:0] rd, input logic [31:0] arg,
		input int pc_off, input logic trap, input int kind);
		t_name[n_entries] = name;
		t_op[n_entries]   = op;
		t_imm[n_entries]  = imm;
		t_addr[n_entries] = addr;
		t_rd[n_entries]   = rd;
		t_arg[n_entries]  = imm ? {27'd0, arg[4:0]} : arg;
		t_pc[n_entries]   = PC_BASE + 32'(4 * n_entries) + 32'(pc_off);
		t_trap[n_entries] = trap;
		t_kind[n_entries] = kind;
		n_entries = n_entries + 1;
	endtask

	task automatic build_table();
		add_entry("mscratch_rw", OP_RW, REG, ADDR_SCRATCH, 5'd1, lcg_next(), 0, 1'b0, PLAIN);
		add_entry("mscratch_rs", OP_RS, REG, ADDR_SCRATCH, 5'd2, lcg_next(), 0, 1'b0, PLAIN);
		add_entry("mscratch_rc", OP_RC, REG, ADDR_SCRATCH, 5'd3, lcg_next(), 0, 1'b0, PLAIN);
		add_entry("mscratch_rwi", OP_RW, IMM, ADDR_SCRATCH, 5'd4, lcg_next(), 0, 1'b0, PLAIN);
		add_entry("mscratch_rsi", OP_RS, IMM, ADDR_SCRATCH, 5'd5, lcg_next(), 0, 1'b0, PLAIN);
		// Low bits forced on so the clear always has set bits to remove
		add_entry("mscratch_rci", OP_RC, IMM, ADDR_SCRATCH, 5'd6, lcg_next() | 32'h3, 0,
			1'b0, PLAIN);
		add_entry("mscratch_read", OP_RS, REG, ADDR_SCRATCH, 5'd7, 32'd0, 0, 1'b0, PLAIN);
		// Low bits forced on to show the mode bits of mtvec cannot be written
		add_entry("mtvec_rw", OP_RW, REG, ADDR_TVEC, 5'd8, lcg_next() | 32'd3, 0, 1'b0, PLAIN);
		add_entry("mtvec_rsi", OP_RS, IMM, ADDR_TVEC, 5'd9, 32'h1f, 0, 1'b0, PLAIN);
		add_entry("mtvec_read", OP_RS, IMM, ADDR_TVEC, 5'd10, 32'd0, 0, 1'b0, PLAIN);
		add_entry("trap_addr", OP_RW, REG, ADDR_BAD, 5'd11, lcg_next(), 0, 1'b1, PLAIN);
		add_entry("trap_pc2", OP_RW, REG, ADDR_SCRATCH, 5'd12, lcg_next(), 2, 1'b1, PLAIN);
		add_entry("trap_pc1", OP_RC, IMM, ADDR_TVEC, 5'd13, lcg_next(), 1, 1'b1, PLAIN);
		add_entry("mscratch_after_trap", OP_RS, REG, ADDR_SCRATCH, 5'd14, 32'd0, 0, 1'b0, PLAIN);
		add_entry("rd0_write", OP_RW, REG, ADDR_SCRATCH, 5'd0, lcg_next(), 0, 1'b0, PLAIN);
		add_entry("rd0_set_zero", OP_RS, REG, ADDR_SCRATCH, 5'd0, 32'd0, 0, 1'b0, PLAIN);
		// Kept well below the wrap point so the range check cannot overflow
		add_entry("mcycle_write", OP_RW, REG, ADDR_CYCLE, 5'd0, lcg_next() & 32'h00ff_ffff, 0,
			1'b0, CYCLE_WRITE);
		add_entry("mcycle_read", OP_RS, IMM, ADDR_CYCLE, 5'd15, 32'd0, 0, 1'b0, CYCLE_READ);
		add_entry("mscratch_final", OP_RS, REG, ADDR_SCRATCH, 5'd16, 32'd0, 0, 1'b0, PLAIN);
		add_entry("mtvec_rc", OP_RC, REG, ADDR_TVEC, 5'd17, lcg_next(), 0, 1'b0, PLAIN);
		add_entry("mtvec_final", OP_RS, IMM, ADDR_TVEC, 5'd18, 32'd0, 0, 1'b0, PLAIN);
	endtask

	// Instructions execute strictly in order, so predicting at issue time
	// matches what each one sees inside the pipeline
	task automatic predict(input int i);
		csr_pkg::word_t old;
		csr_pkg::word_t writable;
		csr_pkg::word_t hit;
		csr_pkg::word_t stored;
		if (t_trap[i]) begin
			e_rd_addr[i]  = 5'd0;
			e_rd_wdata[i] = '0;
			e_pc_wdata[i] = m_mtvec;
			e_rmask[i]    = '0;
			e_wmask[i]    = '0;
			e_rdata[i]    = '0;
			e_wdata[i]    = '0;
		end else begin
			writable = '1;
			if (t_addr[i] == ADDR_SCRATCH) begin
				old = m_mscratch;
			end else if (t_addr[i] == ADDR_TVEC) begin
				old = m_mtvec;
				writable = `CSR_MTVEC_WMASK;
			end else begin
				old = m_mcycle_base;
			end
			hit = t_arg[i] & writable;
			case (t_op[i])
				OP_RW: begin
					e_wmask[i] = writable;
					stored = hit;
				end
				OP_RS: begin
					e_wmask[i] = hit;
					stored = old | hit;
				end
				default: begin
					e_wmask[i] = hit;
					stored = old & ~hit;
				end
			endcase
			e_rd_addr[i]  = t_rd[i];
			e_rd_wdata[i] = (t_rd[i] != 5'd0) ? old : '0;
			e_rmask[i]    = (t_rd[i] != 5'd0) ? '1 : '0;
			e_pc_wdata[i] = t_pc[i] + 32'd4;
			e_rdata[i]    = old;
			e_wdata[i]    = stored;
			if (t_addr[i] == ADDR_SCRATCH) begin
				m_mscratch = stored;
			end else if (t_addr[i] == ADDR_TVEC) begin
				m_mtvec = stored;
			end else if (t_op[i] == OP_RW) begin
				m_mcycle_base = stored;
			end
		end
	endtask

	task automatic check_field(input int idx, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			fail_run($sformatf("FAILED %s %s: expected 0x%h, actual 0x%h",
				t_name[idx], field, expected, actual));
		end
	endtask

	task automatic check_record(input int idx);
		logic [31:0] low;
		check_field(idx, "latency", issue_edge[idx] + LATENCY, edge_count);
		check_field(idx, "trap", {31'd0, t_trap[idx]}, {31'd0, rvfi_trap});
		check_field(idx, "rd_addr", {27'd0, e_rd_addr[idx]}, {27'd0, rvfi_rd_addr});
		check_field(idx, "pc_rdata", t_pc[idx], rvfi_pc_rdata);
		check_field(idx, "pc_wdata", e_pc_wdata[idx], rvfi_pc_wdata);
		check_field(idx, "csr_rmask", e_rmask[idx], rvfi_csr_rmask);
		check_field(idx, "csr_wmask", e_wmask[idx], rvfi_csr_wmask);
		if (t_kind[idx] == CYCLE_READ) begin
			// The counter keeps running, so only a window is predictable
			low = m_mcycle_base;
			assert (rvfi_rd_wdata >= low && rvfi_rd_wdata < low + CYCLE_SPAN) else begin
				fail_run($sformatf("FAILED %s rd_wdata: expected 0x%h to 0x%h, actual 0x%h",
					t_name[idx], low, low + CYCLE_SPAN - 1, rvfi_rd_wdata));
			end
		end else begin
			check_field(idx, "rd_wdata", e_rd_wdata[idx], rvfi_rd_wdata);
			check_field(idx, "csr_wdata", e_wdata[idx], rvfi_csr_wdata);
			if (t_kind[idx] == PLAIN) begin
				check_field(idx, "csr_rdata", e_rdata[idx], rvfi_csr_rdata);
			end
		end
	endtask

	// Counts rising edges and bounds the run
	always @(posedge clock) begin
		edge_count <= edge_count + 1;
		if (edge_count == TIMEOUT_CYCLES) begin
			fail_run("Timeout, not every instruction retired in time");
		end
	end

	// Records are sampled mid-cycle, away from the edge that updates them
	always @(negedge clock) begin : monitor
		int idx;
		if (!reset) begin
			assert (check_error == 1'b0) else begin
				fail_run("The write checker raised check_error");
			end
			if (rvfi_valid) begin
				if (pending_q.size() == 0) begin
					fail_run("A record retired with no instruction outstanding");
				end else begin
					idx = pending_q.pop_front();
					check_record(idx);
					retired = retired + 1;
				end
			end
		end
	end

	initial begin
		reset      = 1'b1;
		insn_valid = 1'b0;
		insn       = '0;
		pc         = '0;
		rs1_rdata  = '0;
		lcg_state  = 32'd70;
		n_entries  = 0;
		m_mscratch = '0;
		m_mtvec    = '0;
		m_mcycle_base = '0;
		build_table();
		assert (n_entries == N_TESTS) else begin
			fail_run("The stimulus table does not hold the expected number of entries");
		end
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		// One strobe per cycle with no gaps
		for (int i = 0; i < N_TESTS; i++) begin
			@(posedge clock);
			insn_valid <= 1'b1;
			insn       <= encode_csr(i);
			pc         <= t_pc[i];
			// Immediate forms get a decoy rs1 value that must be ignored
			rs1_rdata  <= t_imm[i] ? ~t_arg[i] : t_arg[i];
			issue_edge[i] = edge_count + 1;
			predict(i);
			pending_q.push_back(i);
		end
		@(posedge clock);
		insn_valid <= 1'b0;

		while (retired < N_TESTS) begin
			@(negedge clock);
		end
		// A few idle cycles catch any extra record
		repeat (4) @(negedge clock);
		if (!check_error && pending_q.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail_run("The run ended with check_error set or records outstanding");
		end
	end

endmodule

/* files.f */
+incdir+.
csr_pkg.sv
csr_insn_decode.sv
csr_file.sv
csr_retire.sv
csr_write_check.sv
csr_unit_top.sv
tb_csr_unit.sv
